// File: files.f
vld_pkg.sv
vld_addr_gen.sv
vld_resp_collect.sv
vld_writeback.sv
vld_top.sv
tb_vld_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_vld_top -f files.f -o sim_vld

out=$(./obj_dir/sim_vld)
printf '%s\n' "$out"

echo "$out" | grep -qxF '** PASS **'

// File: tb_vld_top.sv
`timescale 1ns/1ps

module tb_vld_top;
    import vld_pkg::*;

    localparam int          LINE_BYTES = 8;
    localparam int          TIMEOUT    = 2000;
    localparam logic [31:0] SEED       = 32'hc3566c67;
    localparam int          IN_ORDER   = 0;
    localparam int          REVERSE    = 1;
    localparam int          SHUFFLE    = 2;

    logic       clk;
    logic       rst_n;
    logic       valid_i;
    vld_instr_t instr_i;
    logic       ready_o;
    logic       req_valid_o;
    vld_req_t   req_o;
    logic       req_grant_i;
    logic       resp_valid_i;
    vld_resp_t  resp_i;
    logic       wb_valid_o;
    vld_wb_t    wb_o;
    logic       wb_grant_i;

    // cache model knobs that change only on a rising edge
    int grant_gap_pct;
    int order_mode;
    int resp_delay;
    int cyc = 0;

    vld_req_t pend_q[$];
    int       due_q[$];
    vld_req_t req_log[$];
    vld_req_t exp_req[$];
    vld_wb_t  wb_log[$];
    vld_wb_t  exp_wb[$];

    int          n_checks;
    int          n_errors;

    vld_top #(
        .LINE_BYTES (LINE_BYTES)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .ready_o      (ready_o),
        .req_valid_o  (req_valid_o),
        .req_o        (req_o),
        .req_grant_i  (req_grant_i),
        .resp_valid_i (resp_valid_i),
        .resp_i       (resp_i),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o),
        .wb_grant_i   (wb_grant_i)
    );

    always #4 clk = ~clk;

    // ========================================
    // memory model
    // ========================================
    function automatic logic [7:0] mem_byte(input logic [31:0] addr);
        return addr[7:0] ^ 8'h5a;
    endfunction

    function automatic int elem_bytes(input vld_esize_e esize);
        case (esize)
            E8:      return 1;
            E16:     return 2;
            default: return 4;
        endcase
    endfunction

    function automatic vld_resp_t make_resp(input vld_req_t req);
        vld_resp_t rsp;
        rsp.tag    = req.tag;
        rsp.nbytes = req.nbytes;
        rsp.data   = '0;
        for (int j = 0; j < int'(req.nbytes); j++) begin
            rsp.data[j*8 +: 8] = mem_byte(req.addr + 32'(j));
        end
        return rsp;
    endfunction

    // grants with random gaps and answers after resp_delay edges
    always @(posedge clk) begin
        int idx;
        resp_valid_i <= 1'b0;
        if (!rst_n) begin
            pend_q.delete();
            due_q.delete();
            req_grant_i <= 1'b0;
        end else begin
            idx = -1;
            if (pend_q.size() > 0) begin
                case (order_mode)
                    REVERSE: if (!req_valid_o) idx = pend_q.size() - 1;
                    SHUFFLE: idx = int'($urandom_range(pend_q.size() - 1, 0));
                    default: idx = 0;
                endcase
            end
            if (idx >= 0) begin
                if (due_q[idx] <= cyc) begin
                    resp_valid_i <= 1'b1;
                    resp_i       <= make_resp(pend_q[idx]);
                    pend_q.delete(idx);
                    due_q.delete(idx);
                end
            end
            if (req_valid_o && req_grant_i) begin
                pend_q.push_back(req_o);
                due_q.push_back(cyc + resp_delay);
                req_log.push_back(req_o);
            end
            req_grant_i <= (int'($urandom_range(99, 0)) >= grant_gap_pct);
        end
        cyc++;
    end

    // writeback sink
    always @(posedge clk) begin
        if (rst_n && wb_valid_o && wb_grant_i) begin
            wb_log.push_back(wb_o);
        end
    end

    // ========================================
    // helpers
    // ========================================
    task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                               input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    function automatic vld_instr_t build_instr(input logic [4:0] dst, input logic [31:0] base,
                                               input logic [31:0] stride, input logic [5:0] vl,
                                               input vld_esize_e esize, input vld_mode_e mode);
        vld_instr_t ins;
        ins.dst    = dst;
        ins.base   = base;
        ins.stride = stride;
        ins.vl     = vl;
        ins.esize  = esize;
        ins.mode   = mode;
        return ins;
    endfunction

    // queue the requests and the register the load should produce
    function automatic void expect_load(input vld_instr_t ins);
        int          eb;
        int          total;
        int          off;
        int          nb;
        vld_req_t    r;
        vld_wb_t     w;
        logic [31:0] a;
        eb    = elem_bytes(ins.esize);
        total = int'(ins.vl) * eb;
        off   = 0;
        while (off < total) begin
            if (ins.mode == STRIDED) begin
                nb     = eb;
                r.addr = ins.base + ins.stride * 32'(off / eb);
            end else begin
                nb     = (total - off < LINE_BYTES) ? total - off : LINE_BYTES;
                r.addr = ins.base + 32'(off);
            end
            r.nbytes = VLD_NB_W'(nb);
            r.tag    = VLD_TAG_W'(off);
            exp_req.push_back(r);
            off += nb;
        end
        w.dst     = ins.dst;
        w.byte_en = '0;
        w.data    = '0;
        for (int i = 0; i < int'(ins.vl); i++) begin
            for (int k = 0; k < eb; k++) begin
                if (ins.mode == STRIDED) begin
                    a = ins.base + ins.stride * 32'(i) + 32'(k);
                end else begin
                    a = ins.base + 32'(i * eb + k);
                end
                w.byte_en[i*eb+k]       = 1'b1;
                w.data[(i*eb+k)*8 +: 8] = mem_byte(a);
            end
        end
        exp_wb.push_back(w);
    endfunction

    task automatic set_cache(input int gap, input int order, input int delay);
        @(posedge clk);
        grant_gap_pct <= gap;
        order_mode    <= order;
        resp_delay    <= delay;
    endtask

    task automatic send_instr(input vld_instr_t ins);
        int t;
        t = 0;
        @(negedge clk);
        while (ready_o !== 1'b1 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (ready_o !== 1'b1) begin
            n_errors++;
            $display("timeout: ready_o never went high");
        end
        @(posedge clk);
        valid_i <= 1'b1;
        instr_i <= ins;
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    task automatic wait_writebacks(input int n);
        int t;
        t = 0;
        @(negedge clk);
        while (wb_log.size() < n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (wb_log.size() < n) begin
            n_errors++;
            $display("timeout: only %0d of %0d writebacks arrived", wb_log.size(), n);
        end
    endtask

    task automatic compare_results(input string name);
        check_value(256'(req_log.size()), 256'(exp_req.size()), {name, ": request count"});
        check_value(256'(pend_q.size()), 256'(0), {name, ": unanswered requests"});
        for (int i = 0; i < req_log.size() && i < exp_req.size(); i++) begin
            check_value(256'(req_log[i].addr), 256'(exp_req[i].addr),
                        $sformatf("%s: req %0d addr", name, i));
            check_value(256'(req_log[i].nbytes), 256'(exp_req[i].nbytes),
                        $sformatf("%s: req %0d nbytes", name, i));
            check_value(256'(req_log[i].tag), 256'(exp_req[i].tag),
                        $sformatf("%s: req %0d tag", name, i));
        end
        check_value(256'(wb_log.size()), 256'(exp_wb.size()), {name, ": writeback count"});
        for (int i = 0; i < wb_log.size() && i < exp_wb.size(); i++) begin
            check_value(256'(wb_log[i].dst), 256'(exp_wb[i].dst),
                        $sformatf("%s: wb %0d dst", name, i));
            check_value(256'(wb_log[i].byte_en), 256'(exp_wb[i].byte_en),
                        $sformatf("%s: wb %0d byte_en", name, i));
            check_value(wb_log[i].data, exp_wb[i].data, $sformatf("%s: wb %0d data", name, i));
        end
        req_log.delete();
        exp_req.delete();
        wb_log.delete();
        exp_wb.delete();
    endtask

    task automatic run_load(input vld_instr_t ins, input string name, output vld_wb_t got);
        expect_load(ins);
        send_instr(ins);
        wait_writebacks(1);
        if (wb_log.size() > 0) begin
            got = wb_log[0];
        end else begin
            got = '0;
        end
        compare_results(name);
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic reset_values();
        @(negedge clk);
        check_value(256'(ready_o), 256'(1), "reset: ready_o");
        check_value(256'(req_valid_o), 256'(0), "reset: req_valid_o");
        check_value(256'(wb_valid_o), 256'(0), "reset: wb_valid_o");
    endtask

    task automatic unit_loads();
        vld_wb_t got;
        run_load(build_instr(5'd3, 32'h0000_1000, '0, 6'd8, E32, UNIT), "unit e32", got);
        // odd length and unaligned base leave a short last request
        run_load(build_instr(5'd4, 32'h0000_2345, '0, 6'd13, E8, UNIT), "unit e8", got);
    endtask

    task automatic strided_loads();
        vld_wb_t got;
        run_load(build_instr(5'd5, 32'h0000_0400, 32'd3, 6'd20, E8, STRIDED),
                 "strided e8", got);
        run_load(build_instr(5'd6, 32'h0000_1234, 32'd6, 6'd11, E16, STRIDED),
                 "strided e16", got);
        // negative stride walks down from base
        run_load(build_instr(5'd8, 32'h0000_0800, 32'hffff_fff8, 6'd5, E32, STRIDED),
                 "strided e32 negative", got);
    endtask

    task automatic reordered_responses();
        vld_instr_t ins[2];
        vld_wb_t    ref_wb;
        vld_wb_t    got;
        ins[0] = build_instr(5'd12, 32'h0000_0a03, 32'd5, 6'd16, E8, STRIDED);
        ins[1] = build_instr(5'd13, 32'h0000_7f00, '0, 6'd16, E16, UNIT);
        for (int n = 0; n < 2; n++) begin
            set_cache(0, IN_ORDER, 1);
            run_load(ins[n], "in order", ref_wb);
            set_cache(40, REVERSE, 3);
            run_load(ins[n], "reverse", got);
            check_value(got.data, ref_wb.data, "reverse against in order");
            set_cache(40, SHUFFLE, 4);
            run_load(ins[n], "shuffle", got);
            check_value(got.data, ref_wb.data, "shuffle against in order");
        end
        set_cache(0, IN_ORDER, 1);
    endtask

    task automatic writeback_stall();
        vld_instr_t a;
        vld_instr_t b;
        vld_wb_t    held;
        int         t;
        a = build_instr(5'd7, 32'h0000_3000, '0, 6'd8, E32, UNIT);
        b = build_instr(5'd9, 32'h0000_5101, 32'd12, 6'd10, E16, STRIDED);
        @(posedge clk);
        wb_grant_i <= 1'b0;
        expect_load(a);
        expect_load(b);
        send_instr(a);
        t = 0;
        @(negedge clk);
        while (wb_valid_o !== 1'b1 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (wb_valid_o !== 1'b1) begin
            n_errors++;
            $display("timeout: first writeback never became valid");
        end
        held = wb_o;
        send_instr(b);
        // second load issues while the first waits for grant
        t = 0;
        while (req_log.size() < exp_req.size() && t < TIMEOUT) begin
            @(negedge clk);
            check_value(256'(wb_valid_o), 256'(1), "stall: wb_valid_o");
            check_value(256'(wb_o.dst), 256'(held.dst), "stall: wb_o dst");
            check_value(256'(wb_o.byte_en), 256'(held.byte_en), "stall: wb_o byte_en");
            check_value(wb_o.data, held.data, "stall: wb_o data");
            t++;
        end
        if (req_log.size() < exp_req.size()) begin
            n_errors++;
            $display("timeout: second load did not issue its requests during the stall");
        end
        @(posedge clk);
        wb_grant_i <= 1'b1;
        wait_writebacks(2);
        compare_results("stall");
    endtask

    // ========================================
    // main
    // ========================================
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        valid_i       = 1'b0;
        instr_i       = '0;
        req_grant_i   = 1'b0;
        resp_valid_i  = 1'b0;
        resp_i        = '0;
        wb_grant_i    = 1'b0;
        grant_gap_pct = 0;
        order_mode    = IN_ORDER;
        resp_delay    = 1;
        n_checks      = 0;
        n_errors      = 0;
        void'($urandom(SEED));
        repeat (10) @(posedge clk);
        rst_n      <= 1'b1;
        wb_grant_i <= 1'b1;
        reset_values();
        unit_loads();
        strided_loads();
        reordered_responses();
        writeback_stall();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vld_top.sv
`timescale 1ns/1ps

module vld_top #(
    parameter int LINE_BYTES = 16
) (
    input  logic                clk,
    input  logic                rst_n,

    // instruction in
    input  logic                valid_i,
    input  vld_pkg::vld_instr_t instr_i,
    output logic                ready_o,

    // data cache request and response
    output logic                req_valid_o,
    output vld_pkg::vld_req_t   req_o,
    input  logic                req_grant_i,
    input  logic                resp_valid_i,
    input  vld_pkg::vld_resp_t  resp_i,

    // register file writeback
    output logic                wb_valid_o,
    output vld_pkg::vld_wb_t    wb_o,
    input  logic                wb_grant_i
);
    import vld_pkg::*;

    logic     gen_idle;
    logic     col_idle;
    logic     accept;
    logic     job_valid;
    vld_job_t job;
    logic     done_valid;
    vld_wb_t  done;
    logic     wb_free;

    // ========================================
    // accept
    // ========================================
    // new instruction only once both generator and collector are free
    assign ready_o = gen_idle & col_idle;
    assign accept  = valid_i & ready_o;

    // ========================================
    // stages
    // ========================================
    vld_addr_gen #(
        .LINE_BYTES (LINE_BYTES)
    ) u_addr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .accept_i    (accept),
        .gen_idle_o  (gen_idle),
        .job_valid_o (job_valid),
        .job_o       (job),
        .req_valid_o (req_valid_o),
        .req_o       (req_o),
        .req_grant_i (req_grant_i)
    );

    vld_resp_collect u_resp_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .job_valid_i  (job_valid),
        .job_i        (job),
        .resp_valid_i (resp_valid_i),
        .resp_i       (resp_i),
        .col_idle_o   (col_idle),
        .done_valid_o (done_valid),
        .done_o       (done),
        .wb_free_i    (wb_free)
    );

    // decouples register file arbitration from collection
    vld_writeback u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .done_valid_i (done_valid),
        .done_i       (done),
        .wb_free_o    (wb_free),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o),
        .wb_grant_i   (wb_grant_i)
    );

endmodule

// File: vld_writeback.sv
`timescale 1ns/1ps

module vld_writeback (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             done_valid_i,
    input  vld_pkg::vld_wb_t done_i,
    output logic             wb_free_o,

    output logic             wb_valid_o,
    output vld_pkg::vld_wb_t wb_o,
    input  logic             wb_grant_i
);
    import vld_pkg::*;

    // one entry that loads only while empty
    logic    full_r;
    vld_wb_t buf_r;
    logic    load;

    assign load = done_valid_i & ~full_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_r <= 1'b0;
        end else if (load) begin
            full_r <= 1'b1;
        end else if (wb_grant_i) begin
            full_r <= 1'b0;
        end
    end

    // payload held until the register file grants
    always_ff @(posedge clk) begin
        if (load) begin
            buf_r <= done_i;
        end
    end

    assign wb_free_o  = ~full_r;
    assign wb_valid_o = full_r;
    assign wb_o       = buf_r;

endmodule

// File: vld_resp_collect.sv
`timescale 1ns/1ps

module vld_resp_collect (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               job_valid_i,
    input  vld_pkg::vld_job_t  job_i,

    input  logic               resp_valid_i,
    input  vld_pkg::vld_resp_t resp_i,

    output logic               col_idle_o,
    output logic               done_valid_o,
    output vld_pkg::vld_wb_t   done_o,
    input  logic               wb_free_i
);
    import vld_pkg::*;

    // ========================================
    // state
    // ========================================
    logic                        busy_r;
    logic                        done_r;
    logic [VLD_VREG_BYTES-1:0]   served_r;
    logic [VLD_VREG_BYTES-1:0]   expect_r;
    logic [VLD_REG_W-1:0]        dst_r;
    logic [VLD_VREG_BYTES*8-1:0] scratch_r;

    logic [VLD_VREG_BYTES-1:0]   served_nxt;
    logic [VLD_VREG_BYTES*8-1:0] scratch_nxt;
    logic                        handoff;

    // place response bytes from tag onward
    always_comb begin
        logic [VLD_TAG_W-1:0] idx;
        served_nxt  = served_r;
        scratch_nxt = scratch_r;
        for (int i = 0; i < VLD_MAX_LINE_BYTES; i++) begin
            idx = resp_i.tag + VLD_TAG_W'(i);
            if (resp_valid_i && (VLD_NB_W'(i) < resp_i.nbytes)) begin
                served_nxt[idx]         = 1'b1;
                scratch_nxt[idx*8 +: 8] = resp_i.data[i*8 +: 8];
            end
        end
    end

    assign handoff = done_r & wb_free_i;

    // ========================================
    // control
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_r   <= 1'b0;
            done_r   <= 1'b0;
            served_r <= '0;
        end else if (job_valid_i) begin
            busy_r   <= 1'b1;
            done_r   <= 1'b0;
            served_r <= '0;
        end else if (handoff) begin
            busy_r <= 1'b0;
            done_r <= 1'b0;
        end else if (busy_r && !done_r) begin
            served_r <= served_nxt;
            // completion registered at the edge of the last response
            done_r   <= (served_nxt == expect_r);
        end
    end

    // scratchpad starts from zero so unused bytes go out as zero
    always_ff @(posedge clk) begin
        if (job_valid_i) begin
            scratch_r <= '0;
            expect_r  <= job_i.expect_mask;
            dst_r     <= job_i.dst;
        end else if (busy_r && !done_r) begin
            scratch_r <= scratch_nxt;
        end
    end

    assign col_idle_o     = ~busy_r;
    assign done_valid_o   = done_r;
    assign done_o.dst     = dst_r;
    assign done_o.byte_en = served_r;
    assign done_o.data    = scratch_r;

endmodule

// File: vld_addr_gen.sv
`timescale 1ns/1ps

module vld_addr_gen #(
    parameter int LINE_BYTES = 16
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                valid_i,
    input  vld_pkg::vld_instr_t instr_i,
    input  logic                accept_i,
    output logic                gen_idle_o,

    output logic                job_valid_o,
    output vld_pkg::vld_job_t   job_o,

    output logic                req_valid_o,
    output vld_pkg::vld_req_t   req_o,
    input  logic                req_grant_i
);
    import vld_pkg::*;

    localparam logic [VLD_CNT_W-1:0] LINE_CNT = VLD_CNT_W'(LINE_BYTES);

    // registered instruction fields
    vld_mode_e              mode_r;
    logic [2:0]             ebytes_r;
    logic [VLD_ADDR_W-1:0]  stride_r;
    logic [VLD_ADDR_W-1:0]  addr_r;
    logic [VLD_TAG_W-1:0]   tag_r;
    logic [VLD_CNT_W-1:0]   remain_r;

    logic [2:0]             in_ebytes;
    logic [VLD_CNT_W-1:0]   in_total;
    logic [VLD_CNT_W-1:0]   unit_cnt;
    logic [VLD_CNT_W-1:0]   req_cnt;
    logic                   req_fire;

    // ========================================
    // accept side
    // ========================================
    assign in_ebytes = vld_esize_bytes(instr_i.esize);
    // vl * element bytes stays within one register
    assign in_total  = VLD_CNT_W'(instr_i.vl * {3'b000, in_ebytes});

    always_comb begin
        logic [VLD_VREG_BYTES:0] mask_wide;
        mask_wide = ({{VLD_VREG_BYTES{1'b0}}, 1'b1} << in_total) - 1'b1;
        job_o.dst         = instr_i.dst;
        job_o.expect_mask = mask_wide[VLD_VREG_BYTES-1:0];
    end

    // job goes out only in the accept cycle
    assign job_valid_o = accept_i & valid_i;

    // ========================================
    // request side
    // ========================================
    assign unit_cnt = (remain_r < LINE_CNT) ? remain_r : LINE_CNT;
    assign req_cnt  = (mode_r == STRIDED) ? {3'b000, ebytes_r} : unit_cnt;

    assign req_valid_o   = (remain_r != '0);
    assign req_o.addr    = addr_r;
    assign req_o.nbytes  = req_cnt[VLD_NB_W-1:0];
    assign req_o.tag     = tag_r;
    assign req_fire      = req_valid_o & req_grant_i;
    assign gen_idle_o    = (remain_r == '0);

    // remaining byte count doubles as the busy state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain_r <= '0;
            tag_r    <= '0;
        end else if (accept_i) begin
            remain_r <= in_total;
            tag_r    <= '0;
        end else if (req_fire) begin
            remain_r <= remain_r - req_cnt;
            tag_r    <= tag_r + req_cnt[VLD_TAG_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            mode_r   <= instr_i.mode;
            ebytes_r <= in_ebytes;
            stride_r <= instr_i.stride;
            addr_r   <= instr_i.base;
        end else if (req_fire) begin
            if (mode_r == STRIDED) begin
                addr_r <= addr_r + stride_r;
            end else begin
                addr_r <= addr_r + VLD_ADDR_W'(req_cnt);
            end
        end
    end

endmodule

// File: vld_pkg.sv
package vld_pkg;

    // ========================================
    // sizes
    // ========================================
    localparam int VLD_ADDR_W         = 32;
    localparam int VLD_VREG_BYTES     = 32;
    localparam int VLD_MAX_LINE_BYTES = 16;

    // tag is a byte offset inside one vector register
    localparam int VLD_TAG_W = $clog2(VLD_VREG_BYTES);
    // request size from 1 up to a full line
    localparam int VLD_NB_W  = $clog2(VLD_MAX_LINE_BYTES) + 1;
    // byte count over a whole register from 0 up to 32
    localparam int VLD_CNT_W = $clog2(VLD_VREG_BYTES) + 1;
    localparam int VLD_VL_W  = 6;
    localparam int VLD_REG_W = 5;

    // ========================================
    // encodings
    // ========================================
    typedef enum logic [1:0] {
        E8  = 2'b00,
        E16 = 2'b01,
        E32 = 2'b10
    } vld_esize_e;

    typedef enum logic {
        UNIT    = 1'b0,
        STRIDED = 1'b1
    } vld_mode_e;

    // ========================================
    // payloads
    // ========================================
    typedef struct packed {
        logic [VLD_REG_W-1:0]  dst;
        logic [VLD_ADDR_W-1:0] base;
        logic [VLD_ADDR_W-1:0] stride;
        logic [VLD_VL_W-1:0]   vl;
        vld_esize_e            esize;
        vld_mode_e             mode;
    } vld_instr_t;

    typedef struct packed {
        logic [VLD_ADDR_W-1:0] addr;
        logic [VLD_NB_W-1:0]   nbytes;
        logic [VLD_TAG_W-1:0]  tag;
    } vld_req_t;

    typedef struct packed {
        logic [VLD_TAG_W-1:0]            tag;
        logic [VLD_NB_W-1:0]             nbytes;
        logic [VLD_MAX_LINE_BYTES*8-1:0] data;
    } vld_resp_t;

    // handed from the address generator to the collector
    typedef struct packed {
        logic [VLD_REG_W-1:0]      dst;
        logic [VLD_VREG_BYTES-1:0] expect_mask;
    } vld_job_t;

    typedef struct packed {
        logic [VLD_REG_W-1:0]        dst;
        logic [VLD_VREG_BYTES-1:0]   byte_en;
        logic [VLD_VREG_BYTES*8-1:0] data;
    } vld_wb_t;

    // bytes per element
    function automatic logic [2:0] vld_esize_bytes(vld_esize_e esize);
        case (esize)
            E8:      return 3'd1;
            E16:     return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage
